//--- all.f
bbox_pkg.sv
bbox_stage_if.sv
bbox_extent.sv
bbox_snap.sv
bbox_clip.sv
bbox_top.sv
tb_bbox.sv

//--- bbox_clip.sv
`timescale 1ns/1ps
`default_nettype none

module bbox_clip (
    input  logic             clk,
    input  logic             rst,
    input  logic             halt,
    input  bbox_pkg::coord_t screen_w,
    input  bbox_pkg::coord_t screen_h,
    bbox_stage_if.dst        s2,
    output bbox_pkg::coord_t out_tri_x [bbox_pkg::N_VERTS],
    output bbox_pkg::coord_t out_tri_y [bbox_pkg::N_VERTS],
    output bbox_pkg::coord_t box_ll_x,
    output bbox_pkg::coord_t box_ll_y,
    output bbox_pkg::coord_t box_ur_x,
    output bbox_pkg::coord_t box_ur_y,
    output logic             out_valid
);
    import bbox_pkg::*;

    // Box after clamping to the screen
    coord_t ll_x_clamp;
    coord_t ll_y_clamp;
    coord_t ur_x_clamp;
    coord_t ur_y_clamp;
    logic   accept;

    // Lower-left stops at the origin
    function automatic coord_t clamp_low(input coord_t v);
        return (v < 0) ? '0 : v;
    endfunction

    // Upper-right stops at the screen edge
    function automatic coord_t clamp_high(input coord_t v, input coord_t lim);
        return (v > lim) ? lim : v;
    endfunction

    always_comb begin
        ll_x_clamp = clamp_low(s2.ll_x);
        ll_y_clamp = clamp_low(s2.ll_y);
        ur_x_clamp = clamp_high(s2.ur_x, screen_w);
        ur_y_clamp = clamp_high(s2.ur_y, screen_h);
        // Reject back faces and boxes wholly off screen
        accept = s2.valid && !s2.cull
              && s2.ur_x >= 0 && s2.ur_y >= 0
              && s2.ll_x <= screen_w && s2.ll_y <= screen_h;
    end

    // Stage 3 register, drives the outputs directly
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            box_ll_x  <= '0;
            box_ll_y  <= '0;
            box_ur_x  <= '0;
            box_ur_y  <= '0;
            out_tri_x <= '{default: '0};
            out_tri_y <= '{default: '0};
        end else if (!halt) begin
            out_valid <= accept;
            box_ll_x  <= ll_x_clamp;
            box_ll_y  <= ll_y_clamp;
            box_ur_x  <= ur_x_clamp;
            box_ur_y  <= ur_y_clamp;
            out_tri_x <= s2.tri_x;
            out_tri_y <= s2.tri_y;
        end
    end

    // Accepted box lies on screen
    assert property (@(posedge clk) disable iff (rst)
        out_valid |-> box_ur_x >= 0 && box_ur_y >= 0
                   && box_ll_x <= screen_w && box_ll_y <= screen_h);

    // Accepted box is never inverted
    assert property (@(posedge clk) disable iff (rst)
        out_valid |-> box_ll_x <= box_ur_x && box_ll_y <= box_ur_y);

endmodule

`default_nettype wire

//--- bbox_extent.sv
`timescale 1ns/1ps
`default_nettype none

module bbox_extent (
    input  logic             clk,
    input  logic             rst,
    input  logic             halt,
    input  bbox_pkg::coord_t tri_x [bbox_pkg::N_VERTS],
    input  bbox_pkg::coord_t tri_y [bbox_pkg::N_VERTS],
    input  logic             in_valid,
    bbox_stage_if.src        s1
);
    import bbox_pkg::*;

    // One-hot vertex selects per corner
    logic [N_VERTS-1:0] sel_ll_x;
    logic [N_VERTS-1:0] sel_ll_y;
    logic [N_VERTS-1:0] sel_ur_x;
    logic [N_VERTS-1:0] sel_ur_y;

    // Unregistered corners
    coord_t ll_x;
    coord_t ll_y;
    coord_t ur_x;
    coord_t ur_y;

    // Edge differences at product width
    prod_t  dx10;
    prod_t  dy21;
    prod_t  dx21;
    prod_t  dy10;
    prod_t  winding;
    logic   cull;

    // Pairwise compare, ties go to the lowest vertex index
    function automatic logic [N_VERTS-1:0] max_sel(input coord_t v [N_VERTS]);
        logic ge01;
        logic ge02;
        logic ge12;
        ge01 = (v[0] >= v[1]);
        ge02 = (v[0] >= v[2]);
        ge12 = (v[1] >= v[2]);
        return {!ge02 && !ge12, !ge01 && ge12, ge01 && ge02};
    endfunction

    function automatic logic [N_VERTS-1:0] min_sel(input coord_t v [N_VERTS]);
        logic le01;
        logic le02;
        logic le12;
        le01 = (v[0] <= v[1]);
        le02 = (v[0] <= v[2]);
        le12 = (v[1] <= v[2]);
        return {!le02 && !le12, !le01 && le12, le01 && le02};
    endfunction

    // AND-OR mux driven by a one-hot select
    function automatic coord_t pick(input logic [N_VERTS-1:0] sel, input coord_t v [N_VERTS]);
        coord_t r;
        r = '0;
        for (int i = 0; i < N_VERTS; i++) begin
            if (sel[i])
                r = r | v[i];
        end
        return r;
    endfunction

    always_comb begin
        sel_ll_x = min_sel(tri_x);
        sel_ll_y = min_sel(tri_y);
        sel_ur_x = max_sel(tri_x);
        sel_ur_y = max_sel(tri_y);
        ll_x     = pick(sel_ll_x, tri_x);
        ll_y     = pick(sel_ll_y, tri_y);
        ur_x     = pick(sel_ur_x, tri_x);
        ur_y     = pick(sel_ur_y, tri_y);
    end

    // Winding test
    // Sign-extend before subtracting so the differences cannot wrap
    always_comb begin
        dx10    = prod_t'(tri_x[1]) - prod_t'(tri_x[0]);
        dy21    = prod_t'(tri_y[2]) - prod_t'(tri_y[1]);
        dx21    = prod_t'(tri_x[2]) - prod_t'(tri_x[1]);
        dy10    = prod_t'(tri_y[1]) - prod_t'(tri_y[0]);
        winding = dx10 * dy21 - dx21 * dy10;
        // Positive winding means back-facing
        cull    = (winding > 0);
    end

    // Stage 1 register
    always_ff @(posedge clk) begin
        if (rst) begin
            s1.valid <= 1'b0;
            s1.cull  <= 1'b0;
            s1.ll_x  <= '0;
            s1.ll_y  <= '0;
            s1.ur_x  <= '0;
            s1.ur_y  <= '0;
            s1.tri_x <= '{default: '0};
            s1.tri_y <= '{default: '0};
        end else if (!halt) begin
            s1.valid <= in_valid;
            s1.cull  <= cull;
            s1.ll_x  <= ll_x;
            s1.ll_y  <= ll_y;
            s1.ur_x  <= ur_x;
            s1.ur_y  <= ur_y;
            s1.tri_x <= tri_x;
            s1.tri_y <= tri_y;
        end
    end

    // Each corner picks exactly one vertex
    assert property (@(posedge clk) disable iff (rst)
        in_valid |-> $onehot(sel_ll_x) && $onehot(sel_ll_y)
                  && $onehot(sel_ur_x) && $onehot(sel_ur_y));

    // Min never exceeds max on either axis
    assert property (@(posedge clk) disable iff (rst)
        in_valid |-> ll_x <= ur_x && ll_y <= ur_y);

endmodule

`default_nettype wire

//--- bbox_pkg.sv
`default_nettype none

package bbox_pkg;

    // Fixed-point coordinate format
    localparam int COORD_W = 24;
    // Default fraction bits of a coordinate
    localparam int FRAC_W = 10;
    // Finest sub-sample grid is an eighth of a pixel
    localparam int SUB_BITS = 3;

    // Vertices per triangle
    localparam int N_VERTS = 3;
    // Register stages from input to output
    localparam int PIPE_DEPTH = 3;

    // Signed fixed-point screen coordinate
    typedef logic signed [COORD_W-1:0] coord_t;

    // Product of two coordinate differences for the winding test
    typedef logic signed [2*COORD_W-1:0] prod_t;

    // One-hot anti-aliasing mode
    typedef logic [3:0] subsample_t;

    // One sample per pixel
    localparam subsample_t SS_1X = 4'b1000;
    // Half-pixel grid
    localparam subsample_t SS_4X = 4'b0100;
    // Quarter-pixel grid
    localparam subsample_t SS_16X = 4'b0010;
    // Eighth-pixel grid
    localparam subsample_t SS_64X = 4'b0001;

endpackage

`default_nettype wire

//--- bbox_snap.sv
`timescale 1ns/1ps
`default_nettype none

module bbox_snap #(
    parameter int FRAC_W = bbox_pkg::FRAC_W
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 halt,
    input  bbox_pkg::subsample_t subsample,
    bbox_stage_if.dst            s1,
    bbox_stage_if.src            s2
);
    import bbox_pkg::*;

    localparam int KEEP_W = $clog2(SUB_BITS + 1);

    // Fraction bits kept by the current grid
    logic [KEEP_W-1:0] keep_bits;
    logic [FRAC_W-1:0] frac_mask;
    coord_t            corner_mask;
    // One grid step in fixed point
    coord_t            grid_step;

    // Corners in order ll_x, ll_y, ur_x, ur_y
    coord_t            raw [4];
    coord_t            snapped [4];

    assign raw[0] = s1.ll_x;
    assign raw[1] = s1.ll_y;
    assign raw[2] = s1.ur_x;
    assign raw[3] = s1.ur_y;

    always_comb begin
        // Unknown codes fall back to one sample per pixel
        case (subsample)
            SS_4X:   keep_bits = KEEP_W'(1);
            SS_16X:  keep_bits = KEEP_W'(2);
            SS_64X:  keep_bits = KEEP_W'(SUB_BITS);
            default: keep_bits = '0;
        endcase
        // Keep the top fraction bits, clear the rest
        frac_mask   = ~({FRAC_W{1'b1}} >> keep_bits);
        // Integer part passes untouched
        corner_mask = {{(COORD_W - FRAC_W){1'b1}}, frac_mask};
        grid_step   = coord_t'(1) << (FRAC_W - int'(keep_bits));
        // Clearing low bits floors even for negative values
        for (int c = 0; c < 4; c++) begin
            snapped[c] = raw[c] & corner_mask;
        end
    end

    // Stage 2 register
    always_ff @(posedge clk) begin
        if (rst) begin
            s2.valid <= 1'b0;
            s2.cull  <= 1'b0;
            s2.ll_x  <= '0;
            s2.ll_y  <= '0;
            s2.ur_x  <= '0;
            s2.ur_y  <= '0;
            s2.tri_x <= '{default: '0};
            s2.tri_y <= '{default: '0};
        end else if (!halt) begin
            s2.valid <= s1.valid;
            s2.cull  <= s1.cull;
            s2.ll_x  <= snapped[0];
            s2.ll_y  <= snapped[1];
            s2.ur_x  <= snapped[2];
            s2.ur_y  <= snapped[3];
            s2.tri_x <= s1.tri_x;
            s2.tri_y <= s1.tri_y;
        end
    end

    // Snap moves a corner down by less than one grid step
    for (genvar c = 0; c < 4; c++) begin : g_snap_chk
        assert property (@(posedge clk) disable iff (rst)
            s1.valid |-> snapped[c] <= raw[c] && (raw[c] - snapped[c]) < grid_step);
    end

endmodule

`default_nettype wire

//--- bbox_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// One pipeline stage worth of box state
interface bbox_stage_if;
    import bbox_pkg::*;

    // Stage holds a live triangle
    logic   valid;
    // Back-facing triangle, to be dropped at the clip stage
    logic   cull;

    // Box corners
    coord_t ll_x;
    coord_t ll_y;
    coord_t ur_x;
    coord_t ur_y;

    // Vertices ride along with the box
    coord_t tri_x [N_VERTS];
    coord_t tri_y [N_VERTS];

    // Producing stage
    modport src (
        output valid, cull, ll_x, ll_y, ur_x, ur_y, tri_x, tri_y
    );

    // Consuming stage
    modport dst (
        input valid, cull, ll_x, ll_y, ur_x, ur_y, tri_x, tri_y
    );

endinterface

`default_nettype wire

//--- bbox_top.sv
`timescale 1ns/1ps
`default_nettype none

module bbox_top #(
    parameter int FRAC_W = bbox_pkg::FRAC_W
) (
    input  logic                 clk,
    input  logic                 rst,

    // Triangle in
    input  bbox_pkg::coord_t     tri_x [bbox_pkg::N_VERTS],
    input  bbox_pkg::coord_t     tri_y [bbox_pkg::N_VERTS],
    input  logic                 in_valid,

    // Stall from the downstream sample test
    input  logic                 halt,

    // Configuration, held stable while triangles are in flight
    input  bbox_pkg::coord_t     screen_w,
    input  bbox_pkg::coord_t     screen_h,
    input  bbox_pkg::subsample_t subsample,

    // Triangle and box out
    output bbox_pkg::coord_t     out_tri_x [bbox_pkg::N_VERTS],
    output bbox_pkg::coord_t     out_tri_y [bbox_pkg::N_VERTS],
    output bbox_pkg::coord_t     box_ll_x,
    output bbox_pkg::coord_t     box_ll_y,
    output bbox_pkg::coord_t     box_ur_x,
    output bbox_pkg::coord_t     box_ur_y,
    output logic                 out_valid
);

    // Extent to snap
    bbox_stage_if s1 ();
    // Snap to clip
    bbox_stage_if s2 ();

    // Stage 1 finds the raw box and the winding
    bbox_extent extent_i (
        .clk      (clk),
        .rst      (rst),
        .halt     (halt),
        .tri_x    (tri_x),
        .tri_y    (tri_y),
        .in_valid (in_valid),
        .s1       (s1.src)
    );

    // Stage 2 floors the box to the sample grid
    bbox_snap #(
        .FRAC_W (FRAC_W)
    ) snap_i (
        .clk       (clk),
        .rst       (rst),
        .halt      (halt),
        .subsample (subsample),
        .s1        (s1.dst),
        .s2        (s2.src)
    );

    // Stage 3 clips to the screen and decides acceptance
    bbox_clip clip_i (
        .clk       (clk),
        .rst       (rst),
        .halt      (halt),
        .screen_w  (screen_w),
        .screen_h  (screen_h),
        .s2        (s2.dst),
        .out_tri_x (out_tri_x),
        .out_tri_y (out_tri_y),
        .box_ll_x  (box_ll_x),
        .box_ll_y  (box_ll_y),
        .box_ur_x  (box_ur_x),
        .box_ur_y  (box_ur_y),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the bounding-box testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_bbox -o sim_bbox

out=$(./obj_dir/sim_bbox)
echo "$out"

# Pass only when the testbench reports success
echo "$out" | grep -qx "TEST OK"

//--- tb_bbox.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bbox;
    import bbox_pkg::*;

    // Whole run plus reset plus margin
    localparam int TIMEOUT_CYCLES = 4 * 405 + 2 + 100;

    // Expected output of one pipeline slot
    typedef struct packed {
        logic             valid;
        coord_t           ll_x;
        coord_t           ll_y;
        coord_t           ur_x;
        coord_t           ur_y;
        coord_t [2:0]     tx;
        coord_t [2:0]     ty;
    } entry_t;

    logic       clk = 1'b0;
    logic       rst;
    coord_t     tri_x [N_VERTS];
    coord_t     tri_y [N_VERTS];
    logic       in_valid;
    logic       halt;
    coord_t     screen_w;
    coord_t     screen_h;
    subsample_t subsample;
    coord_t     out_tri_x [N_VERTS];
    coord_t     out_tri_y [N_VERTS];
    coord_t     box_ll_x;
    coord_t     box_ll_y;
    coord_t     box_ur_x;
    coord_t     box_ur_y;
    logic       out_valid;

    // Model pipeline, slot 2 lines up with the outputs
    entry_t     pipe [PIPE_DEPTH];
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;

    // Per segment: screen in pixels, mode, percent valid, percent halt
    int         seg_w [4] = '{640, 1920, 256, 1280};
    int         seg_h [4] = '{480, 1080, 200, 720};
    subsample_t seg_mode [4] = '{SS_1X, SS_4X, SS_16X, SS_64X};
    int         seg_valid [4] = '{90, 70, 60, 80};
    int         seg_halt [4] = '{0, 25, 40, 10};

    always #5 clk = ~clk;

    bbox_top #(
        .FRAC_W (FRAC_W)
    ) bbox_top_i (
        .clk       (clk),
        .rst       (rst),
        .tri_x     (tri_x),
        .tri_y     (tri_y),
        .in_valid  (in_valid),
        .halt      (halt),
        .screen_w  (screen_w),
        .screen_h  (screen_h),
        .subsample (subsample),
        .out_tri_x (out_tri_x),
        .out_tri_y (out_tri_y),
        .box_ll_x  (box_ll_x),
        .box_ll_y  (box_ll_y),
        .box_ur_x  (box_ur_x),
        .box_ur_y  (box_ur_y),
        .out_valid (out_valid)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    // Floor to the grid step, 1 to 1/8 pixel
    function automatic coord_t snap_floor(input coord_t v, input subsample_t mode);
        int shift;
        case (mode)
            SS_4X:   shift = FRAC_W - 1;
            SS_16X:  shift = FRAC_W - 2;
            SS_64X:  shift = FRAC_W - 3;
            default: shift = FRAC_W;
        endcase
        return (v >>> shift) <<< shift;
    endfunction

    // Expected result for the inputs currently on the pins
    function automatic entry_t predict_entry();
        entry_t e;
        coord_t lo_x;
        coord_t lo_y;
        coord_t hi_x;
        coord_t hi_y;
        longint wind;
        lo_x = tri_x[0];
        hi_x = tri_x[0];
        lo_y = tri_y[0];
        hi_y = tri_y[0];
        for (int i = 0; i < N_VERTS; i++) begin
            if (tri_x[i] < lo_x) lo_x = tri_x[i];
            if (tri_x[i] > hi_x) hi_x = tri_x[i];
            if (tri_y[i] < lo_y) lo_y = tri_y[i];
            if (tri_y[i] > hi_y) hi_y = tri_y[i];
            e.tx[i] = tri_x[i];
            e.ty[i] = tri_y[i];
        end
        wind = (longint'(tri_x[1]) - longint'(tri_x[0]))
               * (longint'(tri_y[2]) - longint'(tri_y[1]))
             - (longint'(tri_x[2]) - longint'(tri_x[1]))
               * (longint'(tri_y[1]) - longint'(tri_y[0]));
        lo_x = snap_floor(lo_x, subsample);
        lo_y = snap_floor(lo_y, subsample);
        hi_x = snap_floor(hi_x, subsample);
        hi_y = snap_floor(hi_y, subsample);
        // Back faces and off-screen boxes are dropped
        e.valid = in_valid && wind <= 0 && hi_x >= 0 && hi_y >= 0
               && lo_x <= screen_w && lo_y <= screen_h;
        e.ll_x  = (lo_x < 0) ? '0 : lo_x;
        e.ll_y  = (lo_y < 0) ? '0 : lo_y;
        e.ur_x  = (hi_x > screen_w) ? screen_w : hi_x;
        e.ur_y  = (hi_y > screen_h) ? screen_h : hi_y;
        return e;
    endfunction

    // Small triangle around a random centre, so some land off screen
    task automatic drive_random_cycle(input int w, input int h, input int valid_pct,
                                      input int halt_pct);
        int cx;
        int cy;
        int px;
        int py;
        cx = int'($urandom_range(w + 64)) - 32;
        cy = int'($urandom_range(h + 64)) - 32;
        for (int i = 0; i < N_VERTS; i++) begin
            px = cx + int'($urandom_range(64)) - 32;
            py = cy + int'($urandom_range(64)) - 32;
            tri_x[i] <= coord_t'((px <<< FRAC_W) + int'($urandom_range((1 << FRAC_W) - 1)));
            tri_y[i] <= coord_t'((py <<< FRAC_W) + int'($urandom_range((1 << FRAC_W) - 1)));
        end
        in_valid <= (int'($urandom_range(99)) < valid_pct);
        halt     <= (int'($urandom_range(99)) < halt_pct);
    endtask

    // Model advances on the same edges as the DUT
    always @(posedge clk) begin
        if (rst) begin
            pipe <= '{default: '0};
        end else if (!halt) begin
            pipe[2] <= pipe[1];
            pipe[1] <= pipe[0];
            pipe[0] <= predict_entry();
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        check_value("out_valid", 32'(pipe[2].valid), 32'(out_valid));
        if (pipe[2].valid && out_valid) begin
            check_value("box_ll_x", 32'(pipe[2].ll_x), 32'(box_ll_x));
            check_value("box_ll_y", 32'(pipe[2].ll_y), 32'(box_ll_y));
            check_value("box_ur_x", 32'(pipe[2].ur_x), 32'(box_ur_x));
            check_value("box_ur_y", 32'(pipe[2].ur_y), 32'(box_ur_y));
            for (int i = 0; i < N_VERTS; i++) begin
                check_value($sformatf("out_tri_x[%0d]", i), 32'(pipe[2].tx[i]), 32'(out_tri_x[i]));
                check_value($sformatf("out_tri_y[%0d]", i), 32'(pipe[2].ty[i]), 32'(out_tri_y[i]));
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(6575));
        rst       = 1'b1;
        halt      = 1'b0;
        in_valid  = 1'b0;
        tri_x     = '{default: '0};
        tri_y     = '{default: '0};
        screen_w  = coord_t'(seg_w[0] <<< FRAC_W);
        screen_h  = coord_t'(seg_h[0] <<< FRAC_W);
        subsample = seg_mode[0];
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int s = 0; s < 4; s++) begin
            // Pipeline is empty here, so the config may change
            screen_w  <= coord_t'(seg_w[s] <<< FRAC_W);
            screen_h  <= coord_t'(seg_h[s] <<< FRAC_W);
            subsample <= seg_mode[s];
            repeat (400) begin
                @(posedge clk);
                drive_random_cycle(seg_w[s], seg_h[s], seg_valid[s], seg_halt[s]);
            end
            // Drain
            repeat (5) begin
                @(posedge clk);
                in_valid <= 1'b0;
                halt     <= 1'b0;
            end
        end
        @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
